// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_ppu -f sim.f -o tb_ppu

# the run may stop with a nonzero status, the log decides
./obj_dir/tb_ppu > sim.log 2>&1 || true
cat sim.log

if grep -q "^Testbench passed$" sim.log; then
	exit 0
else
	exit 1
fi

// File: sim.f
+incdir+verilog
verilog/ppu_regs_pkg.sv
verilog/ppu_video_pkg.sv
verilog/ppu_line_timer.sv
verilog/ppu_reg_file.sv
verilog/ppu_oam_dma.sv
verilog/ppu_bg_fetch.sv
verilog/ppu_top.sv
tb/tb_ppu.sv

// File: tb/tb_ppu.sv
module tb_ppu
	import ppu_regs_pkg::*;
	import ppu_video_pkg::*;
();

	logic        clk_reg;
	logic        reset;
	logic        cpu_req;
	cpu_bus_t    cpu_bus;
	logic        cpu_ack;
	logic [7:0]  cpu_rdata;
	logic        irq;
	logic        lcd_on;
	logic        lcd_clkena;
	logic [1:0]  lcd_data;
	lcd_mode_e   mode;
	logic        vram_rd;
	logic [12:0] vram_addr;
	logic [7:0]  vram_data = 8'h00;
	logic        dma_rd;
	logic [15:0] dma_addr;
	logic [7:0]  dma_data = 8'h00;

	logic [7:0]  vram_mem [0:8191];
	logic [7:0]  tile_rows [0:15];
	logic [31:0] lfsr = 32'h4c05_a296;
	// expected scroll, palette and check enables
	int          scx_exp = 0;
	int          scy_exp = 0;
	logic [7:0]  bgp_exp = 8'hfc;
	logic        bg_en = 1'b1;
	logic        chk = 1'b0;
	logic        irq_oam = 1'b0;
	logic        irq_lyc = 1'b0;
	logic        dma_chk = 1'b0;
	int          dma_len = 0;
	logic [7:0]  rd;

	ppu_top u_dut (.*);

	initial begin
		clk_reg = 1'b0;
		forever #20 clk_reg = ~clk_reg;
	end

	task automatic fail_now(input string why);
		$display("%s", why);
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic check_eq(input string name, input int got, input int exp);
		assert (got == exp) else begin
			$display("ERR %0t %s got %0h expected %0h", $time, name, got, exp);
			fail_now("value mismatch");
		end
	endtask

	// fibonacci lfsr with taps 32 22 2 1 stepped once per bit
	task automatic random_byte(output logic [7:0] b);
		logic fb;
		for (int i = 0; i < 8; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			b = {b[6:0], fb};
		end
	endtask

	// ----------------------------------------------------------
	// memory models with one clock read latency
	// ----------------------------------------------------------
	always @(posedge clk_reg) begin
		if (vram_rd)
			vram_data <= vram_mem[vram_addr];
		// source byte is a fixed function of the low address byte
		if (dma_rd)
			dma_data <= (dma_addr[7:0] * 8'd7) ^ 8'h5a;
	end

	// ----------------------------------------------------------
	// four-phase cpu bus
	// ----------------------------------------------------------
	task automatic cpu_access(input logic sel, input logic wr, input logic [7:0] addr,
		input logic [7:0] wdata, output logic [7:0] rdata);
		int n;
		cpu_req = 1'b1;
		cpu_bus = '{sel_oam: sel, wr: wr, addr: addr, wdata: wdata};
		n = 0;
		while (!cpu_ack) begin
			@(posedge clk_reg);
			#5;
			n++;
			if (n > 20)
				fail_now("no ack on cpu request");
		end
		rdata = cpu_rdata;
		cpu_req = 1'b0;
		n = 0;
		while (cpu_ack) begin
			@(posedge clk_reg);
			#5;
			n++;
			if (n > 20)
				fail_now("ack stuck after req dropped");
		end
	endtask

	task automatic cpu_write(input logic sel, input logic [7:0] addr, input logic [7:0] d);
		logic [7:0] unused;
		cpu_access(sel, 1'b1, addr, d, unused);
	endtask

	task automatic cpu_read(input logic sel, input logic [7:0] addr, output logic [7:0] d);
		cpu_access(sel, 1'b0, addr, 8'h00, d);
	endtask

	// wait for a target line within two frames
	task automatic wait_ly(input int target);
		int n;
		n = 0;
		while (u_dut.timing.ly != target) begin
			@(posedge clk_reg);
			#5;
			n++;
			if (n > 150000)
				fail_now("line counter never reached target line");
		end
	endtask

	// skip to the next frame start and check one whole frame up to the next line 1
	task automatic run_frame;
		wait_ly(150);
		wait_ly(0);
		chk = 1'b1;
		wait_ly(150);
		wait_ly(1);
		chk = 1'b0;
	endtask

	// handshake rules
	a_ack_rise: assert property (@(posedge clk_reg) disable iff (reset)
		(cpu_req && !cpu_ack) |=> cpu_ack) else fail_now("ack late after req");
	a_ack_hold: assert property (@(posedge clk_reg) disable iff (reset)
		(cpu_req && cpu_ack) |=> cpu_ack) else fail_now("ack dropped while req high");
	a_ack_fall: assert property (@(posedge clk_reg) disable iff (reset)
		(!cpu_req && cpu_ack) |=> !cpu_ack) else fail_now("ack held after req low");
	a_dma_page: assert property (@(posedge clk_reg) disable iff (reset)
		(dma_chk && dma_rd) |-> (dma_addr[15:8] == 8'hc1)) else begin
		$display("ERR %0t dma_addr got %0h expected c1xx", $time, dma_addr);
		fail_now("dma page wrong");
	end

	// ----------------------------------------------------------
	// checkers sampled mid-cycle
	// ----------------------------------------------------------
	lcd_mode_e prev_mode = MODE_HBLANK;
	logic [7:0] prev_ly = 8'd0;
	logic run_ok = 1'b0;
	logic ly_ok = 1'b0;
	logic irq_ok = 1'b0;
	int run_len;
	int ly_len;
	int irq_gap;
	int pix_x;
	int row;
	int col;
	logic [1:0] c;
	logic [1:0] exp_px;

	// full run length of each mode with mode 3 grown by the fine scroll
	function automatic int mode_clocks(input lcd_mode_e m);
		case (m)
			MODE_OAM:      return 80;
			MODE_TRANSFER: return 168 + scx_exp % 8;
			MODE_HBLANK:   return 208 - scx_exp % 8;
			default:       return 4560;
		endcase
	endfunction

	always @(negedge clk_reg) begin
		if (dma_rd)
			dma_len++;
		if (!chk) begin
			run_ok = 1'b0;
			ly_ok = 1'b0;
			irq_ok = 1'b0;
			run_len = 0;
			irq_gap = 0;
			pix_x = 0;
		end else begin
			if (mode != prev_mode) begin
				// length of the run that just ended
				if (run_ok)
					check_eq("mode run clocks", run_len, mode_clocks(prev_mode));
				run_ok = 1'b1;
				run_len = 1;
			end else begin
				run_len++;
				// a mode that never ends is caught here
				if (run_len > mode_clocks(mode))
					check_eq("mode run clocks", run_len, mode_clocks(mode));
			end
			if (u_dut.timing.ly != prev_ly) begin
				if (ly_ok)
					check_eq("ly step clocks", ly_len, 456);
				ly_ok = 1'b1;
				ly_len = 1;
			end else begin
				ly_len++;
			end
			check_eq("vblank mode", mode == MODE_VBLANK, u_dut.timing.ly >= 144);
			if (irq) begin
				if (irq_oam && irq_ok)
					check_eq("irq period", irq_gap, 456);
				if (irq_lyc)
					check_eq("irq line", u_dut.timing.ly, 5);
				irq_ok = 1'b1;
				irq_gap = 1;
			end else begin
				irq_gap++;
				// a missing oam pulse shows up as an overlong gap
				if (irq_oam && irq_gap > 456)
					check_eq("irq period", irq_gap, 456);
			end
			// background pixels against the tile model
			if (mode == MODE_OAM)
				pix_x = 0;
			if (lcd_clkena) begin
				check_eq("pixel in vblank", u_dut.timing.ly < 144, 1);
				row = (u_dut.timing.ly + scy_exp) % 8;
				col = 7 - (pix_x + scx_exp) % 8;
				c = {tile_rows[row * 2 + 1][col], tile_rows[row * 2][col]};
				exp_px = bg_en ? bgp_exp[c * 2 +: 2] : 2'b00;
				check_eq("lcd_data", lcd_data, exp_px);
				pix_x++;
			end
			if (prev_mode == MODE_TRANSFER && mode == MODE_HBLANK)
				check_eq("pixels per line", pix_x, 160);
		end
		prev_mode = mode;
		prev_ly = u_dut.timing.ly;
	end

	// ----------------------------------------------------------
	// stimulus
	// ----------------------------------------------------------
	initial begin
		reset = 1'b1;
		cpu_req = 1'b0;
		cpu_bus = '0;
		// background pattern over the whole address before the map and tile 21
		for (int a = 0; a < 8192; a++)
			vram_mem[a] = a[7:0] ^ {3'b000, a[12:8]};
		for (int a = 13'h1800; a < 13'h1c00; a++)
			vram_mem[a] = 8'h21;
		for (int i = 0; i < 16; i++) begin
			random_byte(tile_rows[i]);
			vram_mem[13'h210 + i] = tile_rows[i];
		end
		repeat (8) @(posedge clk_reg);
		#5 reset = 1'b0;

		// outputs idle after reset
		check_eq("cpu_ack", cpu_ack, 0);
		check_eq("irq", irq, 0);
		check_eq("lcd_on", lcd_on, 0);
		check_eq("lcd_clkena", lcd_clkena, 0);
		check_eq("vram_rd", vram_rd, 0);
		check_eq("dma_rd", dma_rd, 0);
		check_eq("mode", mode, MODE_HBLANK);

		// reset values and lcd off
		cpu_read(1'b0, REG_BGP, rd);
		check_eq("bgp reset", rd, 8'hfc);
		cpu_read(1'b0, REG_LCDC, rd);
		check_eq("lcdc reset", rd, 8'h00);
		cpu_read(1'b0, 8'h4f, rd);
		check_eq("unmapped read", rd, 8'hff);
		cpu_read(1'b0, REG_LY, rd);
		check_eq("ly with lcd off", rd, 0);
		check_eq("mode with lcd off", mode, MODE_HBLANK);
		cpu_write(1'b0, REG_SCX, 8'h5a);
		cpu_write(1'b0, REG_SCY, 8'ha5);
		cpu_write(1'b0, REG_LYC, 8'h3c);
		cpu_write(1'b0, REG_BGP, 8'he4);
		cpu_read(1'b0, REG_SCX, rd);
		check_eq("scx", rd, 8'h5a);
		cpu_read(1'b0, REG_SCY, rd);
		check_eq("scy", rd, 8'ha5);
		cpu_read(1'b0, REG_LYC, rd);
		check_eq("lyc", rd, 8'h3c);
		cpu_read(1'b0, REG_BGP, rd);
		check_eq("bgp", rd, 8'he4);
		cpu_read(1'b0, REG_STAT, rd);
		check_eq("stat bit 7", rd[7], 1);

		// display on without scroll and with the oam interrupt
		cpu_write(1'b0, REG_SCX, 8'h00);
		cpu_write(1'b0, REG_SCY, 8'h00);
		bgp_exp = 8'he4;
		cpu_write(1'b0, REG_STAT, 8'h20);
		cpu_write(1'b0, REG_LCDC, 8'h91);
		check_eq("lcd_on", lcd_on, 1);
		irq_oam = 1'b1;
		run_frame();
		irq_oam = 1'b0;

		// coincidence interrupt on line 5
		cpu_write(1'b0, REG_LYC, 8'h05);
		cpu_write(1'b0, REG_STAT, 8'h40);
		irq_lyc = 1'b1;
		wait_ly(150);
		chk = 1'b1;
		for (int n = 0; !irq; n++) begin
			@(posedge clk_reg);
			#5;
			if (n > 150000)
				fail_now("no coincidence interrupt");
		end
		cpu_read(1'b0, REG_STAT, rd);
		check_eq("stat match bits", rd[7:2], 6'b110001);
		cpu_read(1'b0, REG_LY, rd);
		check_eq("ly at match", rd, 5);
		chk = 1'b0;
		irq_lyc = 1'b0;

		// fine and coarse scroll
		cpu_write(1'b0, REG_SCX, 8'h1b);
		cpu_write(1'b0, REG_SCY, 8'h0d);
		scx_exp = 8'h1b;
		scy_exp = 8'h0d;
		run_frame();

		// background disabled shows shade 0
		cpu_write(1'b0, REG_LCDC, 8'h90);
		bg_en = 1'b0;
		run_frame();

		// oam dma from page c1
		dma_len = 0;
		dma_chk = 1'b1;
		cpu_write(1'b0, REG_DMA, 8'hc1);
		for (int n = 0; dma_rd || dma_len == 0; n++) begin
			@(posedge clk_reg);
			#5;
			if (n > 2000)
				fail_now("dma did not finish");
		end
		check_eq("dma_rd clocks", dma_len, 640);
		dma_chk = 1'b0;
		for (int i = 0; i < 160; i++) begin
			cpu_read(1'b1, i[7:0], rd);
			check_eq("oam byte", rd, (i * 7 % 256) ^ 8'h5a);
		end
		cpu_write(1'b1, 8'h10, 8'h3c);
		cpu_read(1'b1, 8'h10, rd);
		check_eq("oam cpu write", rd, 8'h3c);

		$display("Testbench passed");
		$finish;
	end

endmodule

// File: verilog/ppu_bg_fetch.sv
`include "ppu_settings.svh"

module ppu_bg_fetch
	import ppu_regs_pkg::*;
	import ppu_video_pkg::*;
(
	input  logic         clk_reg,
	input  logic         reset,
	input  ppu_regs_t    regs,
	input  line_timing_t timing,
	output logic [2:0]   fine_scroll,
	output logic         vram_rd,
	output logic [12:0]  vram_addr,
	input  logic [7:0]   vram_data,
	output logic         lcd_clkena,
	output logic [1:0]   lcd_data
);

	logic [7:0]   scx_r;
	logic [7:0]   scy_r;
	logic [7:0]   bg_line;
	logic [4:0]   map_col;
	logic [7:0]   tile_num;
	logic [7:0]   data0;
	logic [7:0]   data1;
	logic [7:0]   shift0;
	logic [7:0]   shift1;
	logic         shift_valid;
	logic [2:0]   skip_cnt;
	logic [7:0]   pix_cnt;
	logic         load;
	logic         tile_a12;
	logic [1:0]   colour;
	fetch_phase_e phase;

	// mode 3 starts on an 8 clock boundary, so h_cnt gives the phase
	assign phase = fetch_phase_e'(timing.h_cnt[2:1]);
	assign load = timing.drawing && (phase == PH_LOAD) && timing.h_cnt[0];
	assign bg_line = timing.ly + scy_r;
	assign fine_scroll = scx_r[2:0];

	// scroll is sampled just before the line is fetched
	always_ff @(posedge clk_reg) begin
		if (reset) begin
			scx_r <= 8'h00;
			scy_r <= 8'h00;
		end else if (timing.h_cnt == 9'(`PPU_OAM_LEN - 2)) begin
			scx_r <= regs.scx;
			scy_r <= regs.scy;
		end
	end

	// ----------------------------------------------------------
	// vram fetch, address on the even clock, data on the odd one
	// ----------------------------------------------------------
	assign vram_rd = timing.drawing && (phase != PH_LOAD);
	// signed tile numbers when lcdc bit 4 is clear
	assign tile_a12 = regs.lcdc[4] ? 1'b0 : ~tile_num[7];

	always_comb begin
		if (phase == PH_MAP)
			vram_addr = {2'b11, regs.lcdc[3], bg_line[7:3], map_col};
		else
			vram_addr = {tile_a12, tile_num, bg_line[2:0], phase == PH_DATA1};
	end

	always_ff @(posedge clk_reg) begin
		if (timing.h_cnt == 9'(`PPU_OAM_LEN - 1))
			map_col <= scx_r[7:3];
		if (timing.drawing && timing.h_cnt[0]) begin
			case (phase)
				PH_MAP:   tile_num <= vram_data;
				PH_DATA0: data0 <= vram_data;
				PH_DATA1: data1 <= vram_data;
				// column wraps at 32 tiles
				PH_LOAD:  map_col <= map_col + 5'd1;
			endcase
		end
		// msb first, plane 1 gives the high colour bit
		if (load) begin
			shift0 <= data0;
			shift1 <= data1;
		end else begin
			shift0 <= {shift0[6:0], 1'b0};
			shift1 <= {shift1[6:0], 1'b0};
		end
	end

	// ----------------------------------------------------------
	// fine scroll skip and pixel count
	// ----------------------------------------------------------
	always_ff @(posedge clk_reg) begin
		if (reset || timing.line_start) begin
			shift_valid <= 1'b0;
			skip_cnt <= '0;
			pix_cnt <= '0;
		end else if (load && !shift_valid) begin
			// first tile of the line, drop scx & 7 pixels of it
			shift_valid <= 1'b1;
			skip_cnt <= scx_r[2:0];
		end else if (shift_valid) begin
			if (skip_cnt != 3'd0)
				skip_cnt <= skip_cnt - 3'd1;
			else if (pix_cnt != 8'(`PPU_LINE_PIX))
				pix_cnt <= pix_cnt + 8'd1;
		end
	end

	assign lcd_clkena = timing.drawing && shift_valid && (skip_cnt == 3'd0) &&
		(pix_cnt != 8'(`PPU_LINE_PIX));

	// palette lookup, background off shows shade 0
	assign colour = {shift1[7], shift0[7]};
	assign lcd_data = regs.lcdc[0] ? regs.bgp[{colour, 1'b0} +: 2] : 2'b00;

endmodule

// File: verilog/ppu_line_timer.sv
`include "ppu_settings.svh"

module ppu_line_timer
	import ppu_regs_pkg::*;
	import ppu_video_pkg::*;
(
	input  logic         clk_reg,
	input  logic         reset,
	input  ppu_regs_t    regs,
	input  logic [2:0]   fine_scroll,
	output line_timing_t timing,
	output logic         irq
);

	logic [8:0] h_cnt;
	logic [7:0] v_cnt;
	logic [8:0] mode3_end;
	logic       lcd_en;
	logic       visible;
	logic       lyc_match;
	lcd_mode_e  mode;
	logic       stat_event;
	logic       stat_event_d;

	assign lcd_en = regs.lcdc[7];
	assign visible = (v_cnt < 8'(`PPU_V_VISIBLE));
	assign lyc_match = (v_cnt == regs.lyc);
	// mode 3 grows by the pixels dropped for fine scroll
	assign mode3_end = 9'(`PPU_OAM_LEN + `PPU_LINE_PIX + `PPU_FETCH_LEAD) + {6'd0, fine_scroll};

	// ----------------------------------------------------------
	// h/v counters, held at zero with the lcd off
	// ----------------------------------------------------------
	always_ff @(posedge clk_reg) begin
		if (reset || !lcd_en) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else if (h_cnt == 9'(`PPU_H_LAST)) begin
			h_cnt <= '0;
			if (v_cnt == 8'(`PPU_V_LAST))
				v_cnt <= '0;
			else
				v_cnt <= v_cnt + 8'd1;
		end else begin
			h_cnt <= h_cnt + 9'd1;
		end
	end

	// mode decode, lcd off reads as hblank
	always_comb begin
		if (!lcd_en)
			mode = MODE_HBLANK;
		else if (!visible)
			mode = MODE_VBLANK;
		else if (h_cnt < 9'(`PPU_OAM_LEN))
			mode = MODE_OAM;
		else if (h_cnt < mode3_end)
			mode = MODE_TRANSFER;
		else
			mode = MODE_HBLANK;
	end

	// ----------------------------------------------------------
	// stat interrupt
	// ----------------------------------------------------------
	// one clock strobes, each behind its own enable bit
	assign stat_event = lcd_en && (
		(regs.stat[6] && (h_cnt == 9'd1) && lyc_match) ||
		(regs.stat[5] && (h_cnt == 9'd0)) ||
		(regs.stat[4] && (h_cnt == 9'(`PPU_H_LAST)) && (v_cnt == 8'(`PPU_V_VISIBLE - 1))) ||
		(regs.stat[3] && visible && (h_cnt == mode3_end)));

	// events on adjacent clocks merge into one request, like a shared stat line
	always_ff @(posedge clk_reg) begin
		if (reset) begin
			stat_event_d <= 1'b0;
			irq <= 1'b0;
		end else begin
			stat_event_d <= stat_event;
			irq <= stat_event && !stat_event_d;
		end
	end

	assign timing = '{
		h_cnt:      h_cnt,
		ly:         v_cnt,
		mode:       mode,
		lyc_match:  lyc_match,
		drawing:    (mode == MODE_TRANSFER),
		line_start: (h_cnt == 9'd0)
	};

	a_h_range: assert property (@(posedge clk_reg) disable iff (reset)
		h_cnt <= 9'(`PPU_H_LAST))
		else $error("h_cnt out of range");

	// the cpu sees each stat request as a single pulse
	a_irq_pulse: assert property (@(posedge clk_reg) disable iff (reset)
		irq |=> !irq)
		else $error("irq held for two clocks");

endmodule

// File: verilog/ppu_oam_dma.sv
`include "ppu_settings.svh"

module ppu_oam_dma (
	input  logic        clk_reg,
	input  logic        reset,
	input  logic        dma_start,
	input  logic [7:0]  dma_page,
	output logic        dma_rd,
	output logic [15:0] dma_addr,
	input  logic [7:0]  dma_data,
	input  logic        oam_wr,
	input  logic [7:0]  oam_addr,
	input  logic [7:0]  oam_wdata,
	output logic [7:0]  oam_rdata
);

	logic       dma_active;
	// four clocks per byte, byte index in bits 9:2
	logic [9:0] dma_cnt;
	logic       dma_wr;
	logic       cpu_wr_ok;
	logic [7:0] oam_mem [0:`PPU_OAM_BYTES-1];

	// ----------------------------------------------------------
	// dma sequencer
	// ----------------------------------------------------------
	always_ff @(posedge clk_reg) begin
		if (reset) begin
			dma_active <= 1'b0;
			dma_cnt <= '0;
		end else if (dma_start) begin
			// a new start restarts from byte 0
			dma_active <= 1'b1;
			dma_cnt <= '0;
		end else if (dma_active) begin
			if (dma_cnt == 10'(`PPU_DMA_LEN - 1))
				dma_active <= 1'b0;
			else
				dma_cnt <= dma_cnt + 10'd1;
		end
	end

	assign dma_rd = dma_active;
	assign dma_addr = {dma_page, dma_cnt[9:2]};

	// address goes out at phase 0, source data is valid from phase 1
	assign dma_wr = dma_active && (dma_cnt[1:0] == 2'd2);

	// cpu writes are dropped while dma owns the array
	assign cpu_wr_ok = oam_wr && !dma_active && (oam_addr < 8'(`PPU_OAM_BYTES));

	// ----------------------------------------------------------
	// oam array
	// ----------------------------------------------------------
	always_ff @(posedge clk_reg) begin
		if (dma_wr)
			oam_mem[dma_cnt[9:2]] <= dma_data;
		else if (cpu_wr_ok)
			oam_mem[oam_addr] <= oam_wdata;
	end

	// bus reads ff during dma and past the end of oam
	assign oam_rdata = (dma_active || (oam_addr >= 8'(`PPU_OAM_BYTES))) ?
		8'hff : oam_mem[oam_addr];

	a_dma_in_range: assert property (@(posedge clk_reg) disable iff (reset)
		dma_rd |-> (dma_addr[7:0] < 8'(`PPU_OAM_BYTES)))
		else $error("dma source address past oam size");

endmodule

// File: verilog/ppu_reg_file.sv
module ppu_reg_file
	import ppu_regs_pkg::*;
	import ppu_video_pkg::*;
(
	input  logic         clk_reg,
	input  logic         reset,
	input  logic         cpu_req,
	input  cpu_bus_t     cpu_bus,
	output logic         cpu_ack,
	output logic [7:0]   cpu_rdata,
	input  line_timing_t timing,
	output ppu_regs_t    regs,
	output logic         dma_start,
	output logic [7:0]   dma_page,
	output logic         oam_wr,
	output logic [7:0]   oam_addr,
	output logic [7:0]   oam_wdata,
	input  logic [7:0]   oam_rdata
);

	// ack is high in both ACK and RELEASE
	typedef enum logic [1:0] {
		HS_IDLE,
		HS_ACK,
		HS_RELEASE
	} hs_state_e;

	hs_state_e  hs_state;
	logic       access;
	logic       reg_wr;
	logic [7:0] reg_rdata;

	// ----------------------------------------------------------
	// four-phase handshake
	// ----------------------------------------------------------
	// the access edge is the one that raises ack
	assign access = (hs_state == HS_IDLE) && cpu_req;
	assign cpu_ack = (hs_state != HS_IDLE);

	always_ff @(posedge clk_reg) begin
		if (reset) begin
			hs_state <= HS_IDLE;
		end else begin
			case (hs_state)
				HS_IDLE:
					if (cpu_req)
						hs_state <= HS_ACK;
				// first ack clock, req may already be gone
				HS_ACK:
					hs_state <= cpu_req ? HS_RELEASE : HS_IDLE;
				// hold ack until the master drops req
				HS_RELEASE:
					if (!cpu_req)
						hs_state <= HS_IDLE;
				default:
					hs_state <= HS_IDLE;
			endcase
		end
	end

	// ----------------------------------------------------------
	// register storage
	// ----------------------------------------------------------
	assign reg_wr = access && cpu_bus.wr && !cpu_bus.sel_oam;

	always_ff @(posedge clk_reg) begin
		if (reset) begin
			// lcd starts off so the cpu can fill vram first
			regs <= '{lcdc: 8'h00, stat: 8'h00, scy: 8'h00, scx: 8'h00,
				lyc: 8'h00, bgp: 8'hfc};
			dma_page <= 8'h00;
			dma_start <= 1'b0;
		end else begin
			dma_start <= 1'b0;
			if (reg_wr) begin
				case (reg_addr_e'(cpu_bus.addr))
					REG_LCDC: regs.lcdc <= cpu_bus.wdata;
					// mode and match bits are live, only enables stored
					REG_STAT: regs.stat <= {1'b0, cpu_bus.wdata[6:3], 3'b000};
					REG_SCY:  regs.scy <= cpu_bus.wdata;
					REG_SCX:  regs.scx <= cpu_bus.wdata;
					REG_LYC:  regs.lyc <= cpu_bus.wdata;
					REG_DMA: begin
						dma_page <= cpu_bus.wdata;
						dma_start <= 1'b1;
					end
					REG_BGP:  regs.bgp <= cpu_bus.wdata;
					// ly is read only
					default: ;
				endcase
			end
		end
	end

	// ----------------------------------------------------------
	// read multiplexer
	// ----------------------------------------------------------
	always_comb begin
		case (reg_addr_e'(cpu_bus.addr))
			REG_LCDC: reg_rdata = regs.lcdc;
			REG_STAT: reg_rdata = {1'b1, regs.stat[6:3], timing.lyc_match, timing.mode};
			REG_SCY:  reg_rdata = regs.scy;
			REG_SCX:  reg_rdata = regs.scx;
			REG_LY:   reg_rdata = timing.ly;
			REG_LYC:  reg_rdata = regs.lyc;
			REG_DMA:  reg_rdata = dma_page;
			REG_BGP:  reg_rdata = regs.bgp;
			default:  reg_rdata = 8'hff;
		endcase
	end

	// read data is captured on the access edge
	always_ff @(posedge clk_reg) begin
		if (access && !cpu_bus.wr)
			cpu_rdata <= cpu_bus.sel_oam ? oam_rdata : reg_rdata;
	end

	// oam port, write is a single clock strobe
	assign oam_wr = access && cpu_bus.wr && cpu_bus.sel_oam;
	assign oam_addr = cpu_bus.addr;
	assign oam_wdata = cpu_bus.wdata;

	a_ack_needs_req: assert property (@(posedge clk_reg) disable iff (reset)
		$rose(cpu_ack) |-> $past(cpu_req))
		else $error("ack raised without req");

endmodule

// File: verilog/ppu_regs_pkg.sv
package ppu_regs_pkg;

	// ----------------------------------------------------------
	// cpu register map, low byte of the io address
	// ----------------------------------------------------------
	typedef enum logic [7:0] {
		// display control, bit 7 turns the lcd on
		REG_LCDC = 8'h40,
		// interrupt enables and status
		REG_STAT = 8'h41,
		// background scroll
		REG_SCY  = 8'h42,
		REG_SCX  = 8'h43,
		// current line, read only
		REG_LY   = 8'h44,
		// line compare
		REG_LYC  = 8'h45,
		// writing a page here starts oam dma
		REG_DMA  = 8'h46,
		// background palette
		REG_BGP  = 8'h47
	} reg_addr_e;

	// request fields, held steady while req is high
	typedef struct packed {
		// access targets oam instead of the registers
		logic       sel_oam;
		logic       wr;
		logic [7:0] addr;
		logic [7:0] wdata;
	} cpu_bus_t;

	// register set seen by the timing and fetch blocks
	typedef struct packed {
		logic [7:0] lcdc;
		// only bits 6:3 are kept, the enables
		logic [7:0] stat;
		logic [7:0] scy;
		logic [7:0] scx;
		logic [7:0] lyc;
		// two bits per colour, colour 0 in bits 1:0
		logic [7:0] bgp;
	} ppu_regs_t;

endpackage

// File: verilog/ppu_settings.svh
`ifndef PPU_SETTINGS_SVH
`define PPU_SETTINGS_SVH

// ----------------------------------------------------------
// line and frame timing, one pixel clock per count
// ----------------------------------------------------------

// last h count of a line, 456 clocks per line
`define PPU_H_LAST      455
// last line of a frame, 154 lines
`define PPU_V_LAST      153
// first vblank line
`define PPU_V_VISIBLE   144
// oam search phase length, kept a multiple of 8 for the fetcher
`define PPU_OAM_LEN     80
// visible pixels per line
`define PPU_LINE_PIX    160
// clocks from mode 3 start to the first pixel
`define PPU_FETCH_LEAD  8

// ----------------------------------------------------------
// oam and dma sizes
// ----------------------------------------------------------

// 160 bytes at four clocks per byte
`define PPU_DMA_LEN     640
`define PPU_OAM_BYTES   160

`endif

// File: verilog/ppu_top.sv
module ppu_top
	import ppu_regs_pkg::*;
	import ppu_video_pkg::*;
(
	input  logic        clk_reg,
	input  logic        reset,
	// cpu register and oam bus
	input  logic        cpu_req,
	input  cpu_bus_t    cpu_bus,
	output logic        cpu_ack,
	output logic [7:0]  cpu_rdata,
	output logic        irq,
	// lcd
	output logic        lcd_on,
	output logic        lcd_clkena,
	output logic [1:0]  lcd_data,
	output lcd_mode_e   mode,
	// vram, one clock read latency
	output logic        vram_rd,
	output logic [12:0] vram_addr,
	input  logic [7:0]  vram_data,
	// dma source, one clock read latency
	output logic        dma_rd,
	output logic [15:0] dma_addr,
	input  logic [7:0]  dma_data
);

	ppu_regs_t    regs;
	line_timing_t timing;
	logic [2:0]   fine_scroll;
	logic         dma_start;
	logic [7:0]   dma_page;
	logic         oam_wr;
	logic [7:0]   oam_addr;
	logic [7:0]   oam_wdata;
	logic [7:0]   oam_rdata;

	assign lcd_on = regs.lcdc[7];
	assign mode = timing.mode;

	ppu_line_timer u_timer (
		.clk_reg(clk_reg), .reset(reset), .regs(regs),
		.fine_scroll(fine_scroll), .timing(timing), .irq(irq)
	);

	ppu_reg_file u_regs (
		.clk_reg(clk_reg), .reset(reset), .cpu_req(cpu_req), .cpu_bus(cpu_bus),
		.cpu_ack(cpu_ack), .cpu_rdata(cpu_rdata), .timing(timing), .regs(regs),
		.dma_start(dma_start), .dma_page(dma_page), .oam_wr(oam_wr),
		.oam_addr(oam_addr), .oam_wdata(oam_wdata), .oam_rdata(oam_rdata)
	);

	ppu_oam_dma u_dma (
		.clk_reg(clk_reg), .reset(reset), .dma_start(dma_start), .dma_page(dma_page),
		.dma_rd(dma_rd), .dma_addr(dma_addr), .dma_data(dma_data), .oam_wr(oam_wr),
		.oam_addr(oam_addr), .oam_wdata(oam_wdata), .oam_rdata(oam_rdata)
	);

	ppu_bg_fetch u_fetch (
		.clk_reg(clk_reg), .reset(reset), .regs(regs), .timing(timing),
		.fine_scroll(fine_scroll), .vram_rd(vram_rd), .vram_addr(vram_addr),
		.vram_data(vram_data), .lcd_clkena(lcd_clkena), .lcd_data(lcd_data)
	);

endmodule

// File: verilog/ppu_video_pkg.sv
package ppu_video_pkg;

	// lcd mode as reported in stat bits 1:0
	typedef enum logic [1:0] {
		MODE_HBLANK   = 2'd0,
		MODE_VBLANK   = 2'd1,
		MODE_OAM      = 2'd2,
		MODE_TRANSFER = 2'd3
	} lcd_mode_e;

	// two clocks per phase, taken straight from h_cnt[2:1]
	typedef enum logic [1:0] {
		PH_MAP   = 2'd0,
		PH_DATA0 = 2'd1,
		PH_DATA1 = 2'd2,
		PH_LOAD  = 2'd3
	} fetch_phase_e;

	// ----------------------------------------------------------
	// line timing shared by the register file and the fetcher
	// ----------------------------------------------------------
	typedef struct packed {
		logic [8:0] h_cnt;
		logic [7:0] ly;
		lcd_mode_e  mode;
		// ly equals lyc
		logic       lyc_match;
		// high during mode 3
		logic       drawing;
		// first clock of a line, held while the lcd is off
		logic       line_start;
	} line_timing_t;

endpackage
